// File: dv/branch_vectors.hex
// fetch{valid,branch} pc target resolve{valid,taken} resolve_pc wb{cyc,stb,we} adr dat_w
// expected: next_pc flags{predict_taken,fetch_stall,flush,wb_ack} redirect_pc wb_dat_r
3 0010 0040 0 0000 0 0 0000  0011 0 0000 0000
3 0013 0050 0 0000 0 0 0000  0014 0 0000 0000
3 0025 0060 2 0010 0 0 0000  0026 0 0000 0000
0 0000 0000 2 0013 0 0 0000  0001 0 0000 0000
3 0027 0070 2 0025 0 0 0000  0028 0 0000 0000
3 0028 0080 0 0000 0 0 0000  0029 0 0000 0000
3 0029 0090 3 0027 0 0 0000  002a 0 0000 0000
0 0000 0000 0 0000 0 0 0000  0001 2 0070 0000
3 0027 0070 0 0000 0 0 0000  0070 8 0000 0000
0 0000 0000 3 0027 0 0 0000  0001 0 0000 0000
3 0027 0070 0 0000 0 0 0000  0070 8 0000 0000
0 0000 0000 2 0027 0 0 0000  0001 0 0000 0000
0 0000 0000 0 0000 0 0 0000  0001 2 0028 0000
3 0031 0041 0 0000 0 0 0000  0032 0 0000 0000
3 0032 0042 0 0000 0 0 0000  0033 0 0000 0000
3 0034 0044 0 0000 0 0 0000  0035 0 0000 0000
3 0036 0046 0 0000 0 0 0000  0037 4 0000 0000
3 0036 0046 0 0000 0 0 0000  0037 4 0000 0000
3 0036 0046 2 0031 0 0 0000  0037 0 0000 0000
0 0000 0000 2 0032 0 0 0000  0001 0 0000 0000
0 0000 0000 3 0034 0 0 0000  0001 0 0000 0000
0 0000 0000 0 0000 0 0 0000  0001 2 0044 0000
0 0000 0000 0 0000 6 0 0000  0001 0 0000 0000
0 0000 0000 0 0000 6 0 0000  0001 1 0000 000b
0 0000 0000 0 0000 6 1 0000  0001 0 0000 0000
0 0000 0000 0 0000 6 1 0000  0001 1 0000 0009
0 0000 0000 0 0000 6 2 0000  0001 0 0000 0000
0 0000 0000 0 0000 6 2 0000  0001 1 0000 0003
0 0000 0000 0 0000 7 0 1234  0001 0 0000 0000
0 0000 0000 0 0000 7 0 1234  0001 1 0000 0000
0 0000 0000 0 0000 6 0 0000  0001 0 0000 0000
0 0000 0000 0 0000 6 0 0000  0001 1 0000 0000
0 0000 0000 0 0000 6 1 0000  0001 0 0000 0000
0 0000 0000 0 0000 6 1 0000  0001 1 0000 0000
0 0000 0000 0 0000 6 2 0000  0001 0 0000 0000
0 0000 0000 0 0000 6 2 0000  0001 1 0000 0000

// File: build.f
logic/branch_pkg.sv
logic/stats_pkg.sv
logic/pred_queue_if.sv
logic/branch_history_table.sv
logic/branch_waterfall_queue.sv
logic/branch_ctrl.sv
logic/branch_stats.sv
logic/branch_predict_unit.sv
dv/branch_predict_unit_chk.sv
dv/tb_branch_predict_unit.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_branch_predict_unit -f build.f
./obj_dir/Vtb_branch_predict_unit +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
if grep -q "Done: errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: dv/tb_branch_predict_unit.sv
`timescale 1ns/1ps

module tb_branch_predict_unit;
    import branch_pkg::*;
    import stats_pkg::*;

    localparam int num_vec = 36;
    localparam int fields = 12; // hex words per vector line
    localparam int cycle_limit = num_vec + 20;

    logic clk = 1'b0;
    logic rst_n;

    logic fetch_valid;
    logic fetch_is_branch;
    addr_t fetch_pc;
    addr_t fetch_target;
    addr_t next_pc;
    pred_t predict_taken;
    logic fetch_stall;

    logic resolve_valid;
    addr_t resolve_pc;
    logic resolve_taken;
    logic flush;
    addr_t redirect_pc;

    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    wb_adr_t wb_adr;
    cnt_t wb_dat_w;
    cnt_t wb_dat_r;
    logic wb_ack;

    logic [15:0] vec_mem [num_vec * fields];
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    always #5 clk = ~clk;

    branch_predict_unit u_branch_predict_unit (.*);

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic apply_vector(input int base);
        {fetch_valid, fetch_is_branch} = vec_mem[base][1:0];
        fetch_pc = vec_mem[base + 1];
        fetch_target = vec_mem[base + 2];
        {resolve_valid, resolve_taken} = vec_mem[base + 3][1:0];
        resolve_pc = vec_mem[base + 4];
        {wb_cyc, wb_stb, wb_we} = vec_mem[base + 5][2:0];
        wb_adr = vec_mem[base + 6][1:0];
        wb_dat_w = vec_mem[base + 7];
    endtask

    task automatic check_outputs(input int base);
        logic [15:0] flags;
        flags = vec_mem[base + 9];
        check_value("next_pc", next_pc, vec_mem[base + 8]);
        check_value("predict_taken", 16'(predict_taken), 16'(flags[3]));
        check_value("fetch_stall", 16'(fetch_stall), 16'(flags[2]));
        check_value("flush", 16'(flush), 16'(flags[1]));
        check_value("wb_ack", 16'(wb_ack), 16'(flags[0]));
        if (flags[1]) begin
            check_value("redirect_pc", redirect_pc, vec_mem[base + 10]);
        end
        if (flags[0] && !wb_we) begin // read data only, write ack returns no data
            check_value("wb_dat_r", wb_dat_r, vec_mem[base + 11]);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        int assert_fails;
        rst_n = 1'b0;
        $readmemh("dv/branch_vectors.hex", vec_mem);
        apply_vector(0);
        {fetch_valid, fetch_is_branch, resolve_valid, resolve_taken} = '0;
        {wb_cyc, wb_stb, wb_we} = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < num_vec; i++) begin
            apply_vector(i * fields);
            #4; // just before the next rising edge
            check_outputs(i * fields);
            @(negedge clk);
        end
        assert_fails = u_branch_predict_unit.u_chk.fail_count;
        $display("checks: %0d, value errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : tb_branch_predict_unit

// File: dv/branch_predict_unit_chk.sv
`timescale 1ns/1ps

module branch_predict_unit_chk (
    input logic clk,
    input logic rst_n,
    input logic flush,
    input logic fetch_stall,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack
);
    int fail_count = 0;

    flush_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !flush)
        else begin
            fail_count++;
            $error("flush stayed high for two cycles");
        end

    ack_after_request: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
        else begin
            fail_count++;
            $error("wb_ack rose without cyc and stb in the cycle before");
        end

    // ctrl ignores fetch while flushing
    no_stall_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush |-> !fetch_stall)
        else begin
            fail_count++;
            $error("fetch_stall was high during a flush");
        end

endmodule : branch_predict_unit_chk

bind branch_predict_unit branch_predict_unit_chk u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .fetch_stall (fetch_stall),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_ack      (wb_ack)
);

// File: logic/branch_predict_unit.sv
`timescale 1ns/1ps

module branch_predict_unit (
    input logic clk,
    input logic rst_n,

    // fetch
    input logic fetch_valid,
    input logic fetch_is_branch,
    input branch_pkg::addr_t fetch_pc,
    input branch_pkg::addr_t fetch_target,
    output branch_pkg::addr_t next_pc,
    output branch_pkg::pred_t predict_taken,
    output logic fetch_stall,

    // execute
    input logic resolve_valid,
    input branch_pkg::addr_t resolve_pc,
    input logic resolve_taken,
    output logic flush,
    output branch_pkg::addr_t redirect_pc,

    // wishbone classic slave
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input stats_pkg::wb_adr_t wb_adr,
    input stats_pkg::cnt_t wb_dat_w,
    output stats_pkg::cnt_t wb_dat_r,
    output logic wb_ack
);
    import branch_pkg::*;

    pred_t bht_taken;
    logic ev_issue;
    logic ev_resolve;
    logic ev_mispredict;

    pred_queue_if pq ();

    branch_history_table u_branch_history_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_idx    (bht_idx_t'(fetch_pc[3:0])),
        .rd_taken  (bht_taken),
        .upd_en    (resolve_valid),
        .upd_idx   (bht_idx_t'(resolve_pc[3:0])), // trained by the resolving branch
        .upd_taken (resolve_taken)
    );

    branch_waterfall_queue u_branch_waterfall_queue (
        .clk   (clk),
        .rst_n (rst_n),
        .pq    (pq.queue)
    );

    branch_ctrl u_branch_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_valid     (fetch_valid),
        .fetch_is_branch (fetch_is_branch),
        .fetch_pc        (fetch_pc),
        .fetch_target    (fetch_target),
        .bht_taken       (bht_taken),
        .resolve_valid   (resolve_valid),
        .resolve_taken   (resolve_taken),
        .pq              (pq.ctrl),
        .next_pc         (next_pc),
        .predict_taken   (predict_taken),
        .fetch_stall     (fetch_stall),
        .flush           (flush),
        .redirect_pc     (redirect_pc),
        .ev_issue        (ev_issue),
        .ev_resolve      (ev_resolve),
        .ev_mispredict   (ev_mispredict)
    );

    branch_stats u_branch_stats (
        .clk           (clk),
        .rst_n         (rst_n),
        .ev_issue      (ev_issue),
        .ev_resolve    (ev_resolve),
        .ev_mispredict (ev_mispredict),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack)
    );

endmodule : branch_predict_unit

// File: logic/branch_stats.sv
`timescale 1ns/1ps

module branch_stats (
    input logic clk,
    input logic rst_n,

    input logic ev_issue,
    input logic ev_resolve,
    input logic ev_mispredict,

    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input stats_pkg::wb_adr_t wb_adr,
    input stats_pkg::cnt_t wb_dat_w,
    output stats_pkg::cnt_t wb_dat_r,
    output logic wb_ack
);
    import stats_pkg::*;

    cnt_t issued_cnt;
    cnt_t resolved_cnt;
    cnt_t mispredict_cnt;
    cnt_t rd_data;

    logic access;
    logic wr_clear;

    assign access = wb_cyc & wb_stb & ~wb_ack; // ack drops the cycle after it rises
    assign wr_clear = access & wb_we; // any data value clears

    always_comb begin
        case (wb_adr)
            reg_issued: rd_data = issued_cnt;
            reg_resolved: rd_data = resolved_cnt;
            reg_mispredicts: rd_data = mispredict_cnt;
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_r <= rd_data;
        end
    end

    // clear wins over an event on the same edge
    always_ff @(posedge clk) begin
        if (!rst_n || wr_clear) begin
            issued_cnt <= '0;
            resolved_cnt <= '0;
            mispredict_cnt <= '0;
        end else begin
            if (ev_issue) issued_cnt <= issued_cnt + cnt_t'(1);
            if (ev_resolve) resolved_cnt <= resolved_cnt + cnt_t'(1);
            if (ev_mispredict) mispredict_cnt <= mispredict_cnt + cnt_t'(1);
        end
    end

endmodule : branch_stats

// File: logic/branch_ctrl.sv
`timescale 1ns/1ps

module branch_ctrl (
    input logic clk,
    input logic rst_n,

    input logic fetch_valid,
    input logic fetch_is_branch,
    input branch_pkg::addr_t fetch_pc,
    input branch_pkg::addr_t fetch_target,
    input branch_pkg::pred_t bht_taken,

    input logic resolve_valid,
    input logic resolve_taken,

    pred_queue_if.ctrl pq,

    output branch_pkg::addr_t next_pc,
    output branch_pkg::pred_t predict_taken,
    output logic fetch_stall,
    output logic flush,
    output branch_pkg::addr_t redirect_pc,

    output logic ev_issue,
    output logic ev_resolve,
    output logic ev_mispredict
);
    import branch_pkg::*;

    ctrl_state_t state;
    addr_t pc_plus1;
    logic is_branch;
    logic mispredict;

    assign pc_plus1 = fetch_pc + addr_t'(1);
    assign is_branch = fetch_valid & fetch_is_branch;

    assign predict_taken = is_branch & bht_taken;
    assign next_pc = predict_taken ? fetch_target : pc_plus1;

    // a resolve in the same cycle frees a slot
    assign fetch_stall = is_branch & pq.full & ~resolve_valid & (state == st_run);

    assign mispredict = resolve_valid & (resolve_taken != pq.prediction_out);

    // wrong-path fetch in the mispredict cycle is dropped as well
    assign pq.load_prediction = is_branch & ~fetch_stall & ~mispredict & (state == st_run);
    assign pq.mispredict_address_in = predict_taken ? pc_plus1 : fetch_target;
    assign pq.prediction_in = predict_taken;
    assign pq.update_predictions = resolve_valid;
    assign pq.correct_prediction = ~mispredict;

    assign ev_issue = pq.load_prediction;
    assign ev_resolve = resolve_valid;
    assign ev_mispredict = mispredict;

    assign flush = (state == st_flush);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_run;
            redirect_pc <= '0;
        end else begin
            case (state)
                st_run: begin
                    if (mispredict) begin
                        state <= st_flush;
                        redirect_pc <= pq.mispredict_address_out; // head's alternate path
                    end
                end
                default: state <= st_run; // flush lasts one cycle
            endcase
        end
    end

endmodule : branch_ctrl

// File: logic/branch_waterfall_queue.sv
`timescale 1ns/1ps

module branch_waterfall_queue (
    input logic clk,
    input logic rst_n,

    pred_queue_if.queue pq
);
    import branch_pkg::*;

    addr_t alt_q [queue_depth];
    pred_t pred_q [queue_depth];

    qptr_t top_ptr; // number of valid entries, next free slot
    qptr_t top_ptr_up1;
    qptr_t top_ptr_dn1;

    logic clear;
    logic pop;
    logic push;

    assign top_ptr_up1 = top_ptr + qptr_t'(1);
    assign top_ptr_dn1 = top_ptr - qptr_t'(1);

    assign clear = pq.update_predictions & ~pq.correct_prediction;
    assign pop = pq.update_predictions & pq.correct_prediction;
    assign push = pq.load_prediction & ~pq.full; // a full queue only loads with a pop

    assign pq.full = (top_ptr == qptr_t'(queue_depth));
    assign pq.mispredict_address_out = alt_q[0];
    assign pq.prediction_out = pred_q[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_ptr <= '0;
        end else if (clear) begin
            top_ptr <= '0;
        end else if (pop) begin
            if (!pq.load_prediction) begin
                top_ptr <= top_ptr_dn1;
            end
        end else if (push) begin
            top_ptr <= top_ptr_up1;
        end
    end

    // entries are valid below top_ptr only
    always_ff @(posedge clk) begin
        if (pop) begin
            for (int i = 0; i < queue_depth - 1; i++) begin
                alt_q[i] <= alt_q[i + 1];
                pred_q[i] <= pred_q[i + 1];
            end
            if (pq.load_prediction) begin
                // lands at the top left after the shift
                alt_q[top_ptr_dn1] <= pq.mispredict_address_in;
                pred_q[top_ptr_dn1] <= pq.prediction_in;
            end
        end else if (push && !clear) begin
            alt_q[top_ptr] <= pq.mispredict_address_in;
            pred_q[top_ptr] <= pq.prediction_in;
        end
    end

endmodule : branch_waterfall_queue

// File: logic/branch_history_table.sv
`timescale 1ns/1ps

module branch_history_table (
    input logic clk,
    input logic rst_n,

    input branch_pkg::bht_idx_t rd_idx,
    output branch_pkg::pred_t rd_taken,

    input logic upd_en,
    input branch_pkg::bht_idx_t upd_idx,
    input logic upd_taken
);
    import branch_pkg::*;

    ctr_t table_q [bht_entries];
    ctr_t upd_ctr;

    // upper half of the counter range means taken
    assign rd_taken = table_q[rd_idx][1];

    assign upd_ctr = table_q[upd_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < bht_entries; i++) begin
                table_q[i] <= ctr_t'(1); // weakly not taken
            end
        end else if (upd_en) begin
            if (upd_taken) begin
                if (upd_ctr != ctr_t'(3)) begin
                    table_q[upd_idx] <= upd_ctr + ctr_t'(1);
                end
            end else begin
                if (upd_ctr != ctr_t'(0)) begin
                    table_q[upd_idx] <= upd_ctr - ctr_t'(1);
                end
            end
        end
    end

endmodule : branch_history_table

// File: logic/pred_queue_if.sv
`timescale 1ns/1ps

interface pred_queue_if;
    import branch_pkg::*;

    // ctrl -> queue
    logic load_prediction;
    logic update_predictions;
    logic correct_prediction;
    addr_t mispredict_address_in;
    pred_t prediction_in;

    // queue -> ctrl
    addr_t mispredict_address_out;
    pred_t prediction_out;
    logic full;

    modport ctrl (
        output load_prediction, update_predictions, correct_prediction,
        output mispredict_address_in, prediction_in,
        input mispredict_address_out, prediction_out, full
    );

    modport queue (
        input load_prediction, update_predictions, correct_prediction,
        input mispredict_address_in, prediction_in,
        output mispredict_address_out, prediction_out, full
    );

endinterface : pred_queue_if

// File: logic/stats_pkg.sv
package stats_pkg;

    typedef logic [15:0] cnt_t;   // event counter, wraps
    typedef logic [1:0] wb_adr_t; // wishbone word address

    // register map, address 3 reads zero
    localparam wb_adr_t reg_issued = 2'd0;
    localparam wb_adr_t reg_resolved = 2'd1;
    localparam wb_adr_t reg_mispredicts = 2'd2;

endpackage : stats_pkg

// File: logic/branch_pkg.sv
package branch_pkg;

    // instruction word address, used for pc, targets and redirects
    typedef logic [15:0] addr_t;

    typedef logic pred_t;       // 1 = predicted taken
    typedef logic [1:0] ctr_t;  // 2-bit saturating counter

    // history table, indexed by the low address bits
    localparam int bht_entries = 16;
    typedef logic [3:0] bht_idx_t;

    // in-flight branches held in the queue
    localparam int queue_depth = 3;
    typedef logic [1:0] qptr_t; // counts 0..3, so full is top == 3

    typedef enum logic {
        st_run,
        st_flush
    } ctrl_state_t;

endpackage : branch_pkg
